/* hdl/conv_pkg.sv */
package conv_pkg;

  // ======================================================================
  // datapath widths
  // ======================================================================

  // pixels and weights share one signed width
  localparam int PIX_W  = 8;
  localparam int ACC_W  = 24;
  // 8 address bits cover a 16 by 16 map
  localparam int ADDR_W = 8;
  localparam int SIZE_W = 5;

  // ======================================================================
  // pipeline depths
  // ======================================================================

  // multiplier stages for operands and product
  localparam int D_MAC  = 2;
  // registered read port
  localparam int D_READ = 1;
  // bias, relu and saturation register
  localparam int D_POST = 1;

  // host command opcode
  typedef enum logic {
    OP_ACCUM,
    OP_DRAIN
  } conv_op_e;

  // command FSM
  typedef enum logic [1:0] {
    S_IDLE,
    S_ACCUM,
    S_FLUSH,
    S_DRAIN
  } conv_state_e;

endpackage

/* hdl/conv_ctrl.sv */
`timescale 1ns/1ps

module conv_ctrl
  import conv_pkg::*;
  #( parameter int CREDITS = 4
  )
  ( input  logic                    clk
  , input  logic                    xrst
  , input  logic                    cmd_valid
  , input  conv_op_e                cmd_op
  , input  logic                    cmd_first
  , input  logic [SIZE_W-1:0]       cmd_size
  , input  logic signed [PIX_W-1:0] cmd_weight
  , input  logic signed [PIX_W-1:0] cmd_bias
  , input  logic                    in_valid
  , input  logic                    credit_return
  , output logic                    busy
  , output logic signed [PIX_W-1:0] weight
  , output logic signed [PIX_W-1:0] bias
  , output logic                    mac_en
  , output logic                    mem_we
  , output logic                    mem_clr
  , output logic [ADDR_W-1:0]       mem_waddr
  , output logic                    mem_re
  , output logic [ADDR_W-1:0]       mem_raddr
  , output logic                    post_en
  );

  localparam int CRED_W    = $clog2(CREDITS + 1);
  localparam int FLUSH_MAX = (D_MAC > D_READ + D_POST) ? D_MAC : D_READ + D_POST;
  localparam int FLUSH_W   = $clog2(FLUSH_MAX + 1);

  conv_state_e        state;
  conv_op_e           op_q;
  logic               first_q;
  logic [SIZE_W-1:0]  size_q;
  logic [SIZE_W-1:0]  x_cnt;
  logic [SIZE_W-1:0]  y_cnt;
  logic [ADDR_W-1:0]  addr_cnt;
  logic [FLUSH_W-1:0] flush_cnt;
  logic [CRED_W-1:0]  credit_cnt;
  logic               accept;
  logic               acc_step;
  logic               rd_issue;
  logic               step;
  logic               last_pix;
  logic               we_d   [D_MAC];
  logic               clr_d  [D_MAC];
  logic [ADDR_W-1:0]  addr_d [D_MAC];
  logic               rd_d   [D_READ];

  assign accept   = cmd_valid && state == S_IDLE;
  assign acc_step = state == S_ACCUM && in_valid;
  // drain reads only while a credit is left
  assign rd_issue = state == S_DRAIN && credit_cnt != '0;
  assign step     = acc_step || rd_issue;
  assign last_pix = x_cnt == size_q - 1'b1 && y_cnt == size_q - 1'b1;
  assign busy     = state != S_IDLE;
  assign mac_en   = acc_step;

  // ======================================================================
  // command FSM and command registers
  // ======================================================================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state     <= S_IDLE;
      flush_cnt <= '0;
    end
    else begin
      case (state)
        S_IDLE:
          if (accept)
            state <= (cmd_op == OP_ACCUM) ? S_ACCUM : S_DRAIN;
        S_ACCUM, S_DRAIN:
          if (step && last_pix) begin
            state <= S_FLUSH;
            // wait for the last write, or for the last output pixel
            flush_cnt <= (op_q == OP_ACCUM) ? FLUSH_W'(D_MAC)
                                            : FLUSH_W'(D_READ + D_POST - 1);
          end
        S_FLUSH:
          if (flush_cnt == '0)
            state <= S_IDLE;
          else
            flush_cnt <= flush_cnt - 1'b1;
        default:
          state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      op_q    <= OP_ACCUM;
      first_q <= 1'b0;
      size_q  <= '0;
    end
    else if (accept) begin
      op_q    <= cmd_op;
      first_q <= cmd_first;
      size_q  <= cmd_size;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      weight <= cmd_weight;
      bias   <= cmd_bias;
    end
  end

  // raster position, shared by accumulate and drain
  always_ff @(posedge clk) begin
    if (!xrst || accept) begin
      x_cnt    <= '0;
      y_cnt    <= '0;
      addr_cnt <= '0;
    end
    else if (step) begin
      addr_cnt <= addr_cnt + 1'b1;
      if (x_cnt == size_q - 1'b1) begin
        x_cnt <= '0;
        y_cnt <= y_cnt + 1'b1;
      end
      else
        x_cnt <= x_cnt + 1'b1;
    end
  end

  // ======================================================================
  // delay lines matched to the MAC and read latency
  // ======================================================================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      for (int i = 0; i < D_MAC; i++) begin
        we_d[i]  <= 1'b0;
        clr_d[i] <= 1'b0;
      end
      for (int i = 0; i < D_READ; i++)
        rd_d[i] <= 1'b0;
    end
    else begin
      we_d[0]  <= acc_step;
      clr_d[0] <= acc_step && first_q;
      rd_d[0]  <= rd_issue;
      for (int i = 1; i < D_MAC; i++) begin
        we_d[i]  <= we_d[i-1];
        clr_d[i] <= clr_d[i-1];
      end
      for (int i = 1; i < D_READ; i++)
        rd_d[i] <= rd_d[i-1];
    end
  end

  always_ff @(posedge clk) begin
    addr_d[0] <= addr_cnt;
    for (int i = 1; i < D_MAC; i++)
      addr_d[i] <= addr_d[i-1];
  end

  // old sum is read one stage ahead of the write
  assign mem_re    = rd_issue || we_d[D_MAC-2];
  assign mem_raddr = (state == S_DRAIN) ? addr_cnt : addr_d[D_MAC-2];
  assign mem_we    = we_d[D_MAC-1];
  assign mem_clr   = clr_d[D_MAC-1];
  assign mem_waddr = addr_d[D_MAC-1];
  assign post_en   = rd_d[D_READ-1];

  // credit counter
  always_ff @(posedge clk) begin
    if (!xrst)
      credit_cnt <= CRED_W'(CREDITS);
    else if (rd_issue && !credit_return)
      credit_cnt <= credit_cnt - 1'b1;
    else if (!rd_issue && credit_return)
      credit_cnt <= credit_cnt + 1'b1;
  end

  a_no_cmd_while_busy: assert property (@(posedge clk) disable iff (!xrst)
    cmd_valid |-> !busy)
    else $error("command issued while busy");

  // consumer returned more credits than it was given
  a_credit_bound: assert property (@(posedge clk) disable iff (!xrst)
    credit_cnt <= CRED_W'(CREDITS))
    else $error("credit counter above CREDITS");

  a_in_valid_accum: assert property (@(posedge clk) disable iff (!xrst)
    in_valid |-> state == S_ACCUM)
    else $error("input pixel outside accumulate pass");

endmodule

/* hdl/conv_mac.sv */
`timescale 1ns/1ps

module conv_mac
  import conv_pkg::*;
  ( input  logic                    clk
  , input  logic                    xrst
  , input  logic                    mac_en
  , input  logic signed [PIX_W-1:0] in_pixel
  , input  logic signed [PIX_W-1:0] weight
  , output logic signed [ACC_W-1:0] product
  );

  logic signed [PIX_W-1:0] pix_q;
  logic signed [PIX_W-1:0] wgt_q;
  logic signed [ACC_W-1:0] prod_q [D_MAC-1];

  // ======================================================================
  // operand stage
  // ======================================================================

  // idle cycles load zero so later stages carry zero
  always_ff @(posedge clk) begin
    if (!xrst) begin
      pix_q <= '0;
      wgt_q <= '0;
    end
    else if (mac_en) begin
      pix_q <= in_pixel;
      wgt_q <= weight;
    end
    else begin
      pix_q <= '0;
      wgt_q <= '0;
    end
  end

  // ======================================================================
  // product stages
  // ======================================================================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      for (int i = 0; i < D_MAC - 1; i++)
        prod_q[i] <= '0;
    end
    else begin
      // signed operands extended to the accumulator width
      prod_q[0] <= pix_q * wgt_q;
      for (int i = 1; i < D_MAC - 1; i++)
        prod_q[i] <= prod_q[i-1];
    end
  end

  assign product = prod_q[D_MAC-2];

endmodule

/* hdl/feat_accum_mem.sv */
`timescale 1ns/1ps

module feat_accum_mem
  import conv_pkg::*;
  #( parameter int DEPTH = 256
  )
  ( input  logic                    clk
  , input  logic                    xrst
  , input  logic                    we
  , input  logic                    clr
  , input  logic [ADDR_W-1:0]       waddr
  , input  logic                    re
  , input  logic [ADDR_W-1:0]       raddr
  , input  logic signed [ACC_W-1:0] product
  , output logic signed [ACC_W-1:0] rd_sum
  );

  logic signed [ACC_W-1:0] ram [DEPTH];
  logic                    wr_en_q;
  logic [ADDR_W-1:0]       wr_addr_q;
  logic signed [ACC_W-1:0] wr_data_q;

  // ======================================================================
  // read port
  // ======================================================================

  // shared by the old sum fetch and the drain
  always_ff @(posedge clk) begin
    if (re)
      rd_sum <= ram[raddr];
  end

  // ======================================================================
  // read-modify-write
  // ======================================================================

  always_ff @(posedge clk) begin
    if (!xrst)
      wr_en_q <= 1'b0;
    else
      wr_en_q <= we;
  end

  // first pass of a layer overwrites whatever is left in the RAM
  always_ff @(posedge clk) begin
    if (we) begin
      wr_addr_q <= waddr;
      wr_data_q <= clr ? product : rd_sum + product;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en_q)
      ram[wr_addr_q] <= wr_data_q;
  end

  // raster order never revisits an address within one pass
  a_no_rw_collision: assert property (@(posedge clk) disable iff (!xrst)
    (re && wr_en_q) |-> raddr != wr_addr_q)
    else $error("read and write to the same address");

endmodule

/* hdl/conv_post.sv */
`timescale 1ns/1ps

module conv_post
  import conv_pkg::*;
  ( input  logic                    clk
  , input  logic                    xrst
  , input  logic                    en
  , input  logic signed [ACC_W-1:0] rd_sum
  , input  logic signed [PIX_W-1:0] bias
  , output logic                    out_valid
  , output logic signed [PIX_W-1:0] out_pixel
  );

  // one guard bit for the bias add
  localparam int SUM_W = ACC_W + 1;
  localparam logic signed [SUM_W-1:0] PIX_MAX = SUM_W'((1 << (PIX_W - 1)) - 1);

  logic signed [SUM_W-1:0] biased;
  logic signed [PIX_W-1:0] shaped;

  // both operands signed, so the bias is sign-extended
  assign biased = rd_sum + bias;

  // relu, then clamp to the largest pixel
  always_comb begin
    if (biased < 0)
      shaped = '0;
    else if (biased > PIX_MAX)
      shaped = PIX_MAX[PIX_W-1:0];
    else
      shaped = biased[PIX_W-1:0];
  end

  always_ff @(posedge clk) begin
    if (!xrst)
      out_valid <= 1'b0;
    else
      out_valid <= en;
  end

  always_ff @(posedge clk) begin
    if (en)
      out_pixel <= shaped;
  end

endmodule

/* hdl/conv_layer_top.sv */
`timescale 1ns/1ps

module conv_layer_top
  import conv_pkg::*;
  #( parameter int CREDITS = 4
   , parameter int DEPTH   = 256
  )
  ( input  logic                    clk
  , input  logic                    xrst
  , input  logic                    cmd_valid
  , input  conv_op_e                cmd_op
  , input  logic                    cmd_first
  , input  logic [SIZE_W-1:0]       cmd_size
  , input  logic signed [PIX_W-1:0] cmd_weight
  , input  logic signed [PIX_W-1:0] cmd_bias
  , output logic                    busy
  , input  logic                    in_valid
  , input  logic signed [PIX_W-1:0] in_pixel
  , output logic                    out_valid
  , output logic signed [PIX_W-1:0] out_pixel
  , input  logic                    credit_return
  );

  logic                    mac_en;
  logic                    mem_we;
  logic                    mem_clr;
  logic [ADDR_W-1:0]       mem_waddr;
  logic                    mem_re;
  logic [ADDR_W-1:0]       mem_raddr;
  logic                    post_en;
  logic signed [PIX_W-1:0] weight;
  logic signed [PIX_W-1:0] bias;
  logic signed [ACC_W-1:0] product;
  logic signed [ACC_W-1:0] rd_sum;

  // ======================================================================
  // control
  // ======================================================================

  conv_ctrl #(
    .CREDITS (CREDITS)
  ) conv_ctrl_inst (
    .clk           (clk),
    .xrst          (xrst),
    .cmd_valid     (cmd_valid),
    .cmd_op        (cmd_op),
    .cmd_first     (cmd_first),
    .cmd_size      (cmd_size),
    .cmd_weight    (cmd_weight),
    .cmd_bias      (cmd_bias),
    .in_valid      (in_valid),
    .credit_return (credit_return),
    .busy          (busy),
    .weight        (weight),
    .bias          (bias),
    .mac_en        (mac_en),
    .mem_we        (mem_we),
    .mem_clr       (mem_clr),
    .mem_waddr     (mem_waddr),
    .mem_re        (mem_re),
    .mem_raddr     (mem_raddr),
    .post_en       (post_en)
  );

  // ======================================================================
  // datapath
  // ======================================================================

  conv_mac conv_mac_inst (
    .clk      (clk),
    .xrst     (xrst),
    .mac_en   (mac_en),
    .in_pixel (in_pixel),
    .weight   (weight),
    .product  (product)
  );

  feat_accum_mem #(
    .DEPTH (DEPTH)
  ) feat_accum_mem_inst (
    .clk     (clk),
    .xrst    (xrst),
    .we      (mem_we),
    .clr     (mem_clr),
    .waddr   (mem_waddr),
    .re      (mem_re),
    .raddr   (mem_raddr),
    .product (product),
    .rd_sum  (rd_sum)
  );

  conv_post conv_post_inst (
    .clk       (clk),
    .xrst      (xrst),
    .en        (post_en),
    .rd_sum    (rd_sum),
    .bias      (bias),
    .out_valid (out_valid),
    .out_pixel (out_pixel)
  );

endmodule

/* tests/tb_conv_checks.svh */
`ifndef TB_CONV_CHECKS_SVH
`define TB_CONV_CHECKS_SVH

  // ======================================================================
  // reference accumulation model
  // ======================================================================

  // one sum per raster address
  int ref_acc [256];

  // first pass overwrites, later passes add
  task automatic ref_accum(input logic first, input logic signed [PIX_W-1:0] weight);
    foreach (pix_q[i]) begin
      if (first)
        ref_acc[i] = int'(weight) * int'(pix_q[i]);
      else
        ref_acc[i] = ref_acc[i] + int'(weight) * int'(pix_q[i]);
    end
  endtask

  // bias, relu, then clamp to the largest signed pixel
  function automatic logic signed [PIX_W-1:0] relu_sat(input int sum,
                                                       input logic signed [PIX_W-1:0] bias);
    int v;
    int pix_max;
    v = sum + int'(bias);
    pix_max = (1 << (PIX_W - 1)) - 1;
    if (v < 0)
      return '0;
    else if (v > pix_max)
      return PIX_W'(pix_max);
    else
      return PIX_W'(v);
  endfunction

  // ======================================================================
  // compare tasks
  // ======================================================================

  task automatic check_pixel(input int idx, input logic signed [PIX_W-1:0] got,
                             input logic signed [PIX_W-1:0] exp);
    if (got !== exp)
      fail_run($sformatf("Mismatch at %0t: out_pixel[%0d] got %0d expected %0d",
                         $time, idx, got, exp));
  endtask

  task automatic check_busy(input logic exp);
    if (busy !== exp)
      fail_run($sformatf("Mismatch at %0t: busy got %b expected %b", $time, busy, exp));
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp)
      fail_run($sformatf("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp));
  endtask

`endif

/* tests/tb_conv_layer.sv */
`timescale 1ns/1ps

module tb_conv_layer
  import conv_pkg::*;
  ();

  localparam int CREDITS = 4;
  localparam int TIMEOUT = 4000;

  logic                    clk;
  logic                    xrst;
  logic                    cmd_valid;
  conv_op_e                cmd_op;
  logic                    cmd_first;
  logic [SIZE_W-1:0]       cmd_size;
  logic signed [PIX_W-1:0] cmd_weight;
  logic signed [PIX_W-1:0] cmd_bias;
  logic                    busy;
  logic                    in_valid;
  logic signed [PIX_W-1:0] in_pixel;
  logic                    out_valid;
  logic signed [PIX_W-1:0] out_pixel;
  logic                    credit_return;

  logic signed [PIX_W-1:0] pix_q [$];
  logic signed [PIX_W-1:0] out_q [$];
  int                      credit_due [$];
  int                      due_cycle;
  int                      cycle;
  int                      outstanding;
  int                      max_outstanding;
  int                      slow_extra;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopped at first error");
  endtask

`include "tb_conv_checks.svh"

  conv_layer_top #(
    .CREDITS (CREDITS),
    .DEPTH   (256)
  ) conv_layer_top_inst (
    .clk           (clk),
    .xrst          (xrst),
    .cmd_valid     (cmd_valid),
    .cmd_op        (cmd_op),
    .cmd_first     (cmd_first),
    .cmd_size      (cmd_size),
    .cmd_weight    (cmd_weight),
    .cmd_bias      (cmd_bias),
    .busy          (busy),
    .in_valid      (in_valid),
    .in_pixel      (in_pixel),
    .out_valid     (out_valid),
    .out_pixel     (out_pixel),
    .credit_return (credit_return)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ======================================================================
  // consumer model
  // ======================================================================

  // one credit per cycle at most, in arrival order
  initial begin
    cycle = 0;
    credit_return = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      cycle++;
      if (credit_due.size() > 0 && credit_due[0] <= cycle) begin
        void'(credit_due.pop_front());
        credit_return = 1'b1;
        outstanding--;
      end
      else
        credit_return = 1'b0;
    end
  end

  always @(negedge clk) begin
    if (xrst && out_valid) begin
      out_q.push_back(out_pixel);
      outstanding++;
      if (outstanding > max_outstanding)
        max_outstanding = outstanding;
      if (outstanding > CREDITS)
        fail_run($sformatf("more pixels than credits at %0t: %0d unreturned",
                           $time, outstanding));
      due_cycle = cycle + 1 + slow_extra + int'($urandom_range(5));
      if (credit_due.size() > 0 && due_cycle <= credit_due[$])
        due_cycle = credit_due[$] + 1;
      credit_due.push_back(due_cycle);
    end
  end

  // ======================================================================
  // drivers and waits
  // ======================================================================

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic wait_idle();
    int t;
    t = 0;
    while (busy) begin
      if (t == TIMEOUT)
        fail_run("timeout waiting for busy to fall");
      else begin
        t++;
        next_cycle();
      end
    end
  endtask

  task automatic wait_outputs(input int n);
    int t;
    t = 0;
    while (out_q.size() < n) begin
      if (t == TIMEOUT)
        fail_run("timeout waiting for drained pixels");
      else begin
        t++;
        next_cycle();
      end
    end
  endtask

  task automatic wait_credits_done();
    int t;
    t = 0;
    while (credit_due.size() > 0 || outstanding != 0) begin
      if (t == TIMEOUT)
        fail_run("timeout waiting for the consumer to return its credits");
      else begin
        t++;
        next_cycle();
      end
    end
  endtask

  task automatic send_cmd(input conv_op_e op, input logic first, input int size,
                          input int weight, input int bias);
    wait_idle();
    cmd_valid  = 1'b1;
    cmd_op     = op;
    cmd_first  = first;
    cmd_size   = SIZE_W'(size);
    cmd_weight = PIX_W'(weight);
    cmd_bias   = PIX_W'(bias);
    next_cycle();
    cmd_valid = 1'b0;
    check_busy(1'b1);
  endtask

  task automatic fill_pixels(input int n, input int lo, input int hi);
    pix_q.delete();
    for (int i = 0; i < n; i++)
      pix_q.push_back(PIX_W'(lo + int'($urandom_range(hi - lo))));
  endtask

  // random idle cycles between pixels
  task automatic stream_pixels(input int gap_max);
    int gap;
    foreach (pix_q[i]) begin
      gap = int'($urandom_range(gap_max));
      in_valid = 1'b0;
      repeat (gap) next_cycle();
      in_valid = 1'b1;
      in_pixel = pix_q[i];
      next_cycle();
    end
    in_valid = 1'b0;
  endtask

  task automatic run_accum(input logic first, input int size, input int weight,
                           input int lo, input int hi, input int gap_max);
    fill_pixels(size * size, lo, hi);
    ref_accum(first, PIX_W'(weight));
    send_cmd(OP_ACCUM, first, size, weight, 0);
    stream_pixels(gap_max);
    wait_idle();
  endtask

  task automatic drain_check(input int size, input int bias);
    out_q.delete();
    send_cmd(OP_DRAIN, 1'b0, size, 0, bias);
    wait_idle();
    wait_outputs(size * size);
    check_count("drained pixels", out_q.size(), size * size);
    foreach (out_q[i])
      check_pixel(i, out_q[i], relu_sat(ref_acc[i], PIX_W'(bias)));
  endtask

  // ======================================================================
  // directed tests
  // ======================================================================

  task automatic test_reset_state();
    out_q.delete();
    repeat (20) begin
      check_busy(1'b0);
      next_cycle();
    end
    check_count("out_valid pulses", out_q.size(), 0);
  endtask

  task automatic test_single_channel();
    run_accum(1'b1, 4, 1 + int'($urandom_range(6)), 0, 15, 0);
    drain_check(4, int'($urandom_range(40)) - 20);
  endtask

  task automatic test_multi_channel();
    run_accum(1'b1, 6, int'($urandom_range(6)) - 3, -20, 20, 3);
    run_accum(1'b0, 6, int'($urandom_range(6)) - 3, -20, 20, 3);
    run_accum(1'b0, 6, int'($urandom_range(6)) - 3, -20, 20, 3);
    drain_check(6, int'($urandom_range(20)) - 10);
  endtask

  task automatic test_first_clears();
    run_accum(1'b0, 6, 3, 0, 30, 1);
    run_accum(1'b1, 6, 2, 0, 20, 1);
    drain_check(6, 5);
  endtask

  task automatic test_credit_limit();
    slow_extra = 8;
    max_outstanding = 0;
    run_accum(1'b1, 8, 1, 0, 60, 0);
    drain_check(8, 0);
    check_count("peak unreturned credits", max_outstanding, CREDITS);
    wait_credits_done();
    slow_extra = 0;
  endtask

  task automatic test_negative_and_saturation();
    run_accum(1'b1, 4, -5, 1, 100, 2);
    drain_check(4, 0);
    foreach (out_q[i])
      check_pixel(i, out_q[i], 0);
    run_accum(1'b1, 4, 100, 50, 127, 2);
    drain_check(4, 0);
    foreach (out_q[i])
      check_pixel(i, out_q[i], 127);
  endtask

  initial begin
    void'($urandom(32'h4d4f_e45b));
    outstanding     = 0;
    max_outstanding = 0;
    slow_extra      = 0;
    xrst       = 1'b0;
    cmd_valid  = 1'b0;
    cmd_op     = OP_ACCUM;
    cmd_first  = 1'b0;
    cmd_size   = '0;
    cmd_weight = '0;
    cmd_bias   = '0;
    in_valid   = 1'b0;
    in_pixel   = '0;
    repeat (16) @(posedge clk);
    #1;
    xrst = 1'b1;

    test_reset_state();
    test_single_channel();
    test_multi_channel();
    test_first_clears();
    test_credit_limit();
    test_negative_and_saturation();
    wait_credits_done();

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

/* sim.f */
+incdir+tests
hdl/conv_pkg.sv
hdl/conv_ctrl.sv
hdl/conv_mac.sv
hdl/feat_accum_mem.sv
hdl/conv_post.sv
hdl/conv_layer_top.sv
tests/tb_conv_layer.sv

/* run.sh */
#!/bin/sh
# build the conv layer testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_conv_layer -f sim.f &&
./obj_dir/Vtb_conv_layer | tee /dev/stderr | grep -qF '*** TEST PASSED ***' &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }
